/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;

	// Major opcodes, instr[31:26]
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opJal   = 6'h03;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opBne   = 6'h05;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opAndi  = 6'h0c;
	localparam logic [5:0] opOri   = 6'h0d;
	localparam logic [5:0] opLui   = 6'h0f;
	localparam logic [5:0] opLb    = 6'h20;
	localparam logic [5:0] opLh    = 6'h21;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opLbu   = 6'h24;
	localparam logic [5:0] opLhu   = 6'h25;
	localparam logic [5:0] opSb    = 6'h28;
	localparam logic [5:0] opSh    = 6'h29;
	localparam logic [5:0] opSw    = 6'h2b;

	// R-type function field, instr[5:0]
	localparam logic [5:0] fnSll  = 6'h00;
	localparam logic [5:0] fnSrl  = 6'h02;
	localparam logic [5:0] fnSra  = 6'h03;
	localparam logic [5:0] fnJr   = 6'h08;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnXor  = 6'h26;
	localparam logic [5:0] fnSlt  = 6'h2a;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluSrl, aluSra, aluLui
	} aluOpT;

	// extShift2 is for branch offsets
	typedef enum logic [1:0] {extZero, extSign, extShift2} extModeT;

	typedef enum logic [1:0] {sizeByte, sizeHalf, sizeWord} memSizeT;

	typedef enum logic [1:0] {wbAlu, wbLoad, wbLink} wbSelT;

endpackage

`default_nettype wire

/* nextPc.sv */
`timescale 1ns/10ps
`default_nettype none

module nextPc #(
	parameter logic [cpuPkg::dataWidth-1:0] resetPc = '0
) (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic [cpuPkg::dataWidth-1:0]  branchImm,
	input  logic [25:0]                   jumpImm,
	input  logic [cpuPkg::dataWidth-1:0]  regTarget,
	input  logic                          branchTaken,
	input  logic                          jump,
	input  logic                          jumpReg,
	output logic [cpuPkg::dataWidth-1:0]  pc,
	output logic [cpuPkg::dataWidth-1:0]  pcPlus4
);
	import cpuPkg::*;

	logic [dataWidth-1:0] pcNext;

	assign pcPlus4 = pc + dataWidth'(4);

	// Register jump wins over direct jump, then branch
	always_comb begin
		if (jumpReg) begin
			pcNext = regTarget;
		end else if (jump) begin
			pcNext = {pc[dataWidth-1:28], jumpImm, 2'b00};
		end else if (branchTaken) begin
			pcNext = pcPlus4 + branchImm;
		end else begin
			pcNext = pcPlus4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= resetPc;
		end else begin
			pc <= pcNext;
		end
	end

	// A misaligned jr target would show up here
	pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
		else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic [cpuPkg::regAddrWidth-1:0] rdAddrA,
	input  logic [cpuPkg::regAddrWidth-1:0] rdAddrB,
	input  logic [cpuPkg::regAddrWidth-1:0] wrAddr,
	input  logic [cpuPkg::dataWidth-1:0]    wrData,
	input  logic                            we,
	output logic [cpuPkg::dataWidth-1:0]    rdDataA,
	output logic [cpuPkg::dataWidth-1:0]    rdDataB
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regs [32];

	// r0 is never written
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// r0 keeps its reset value
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

	// Also holds in the cycle after a write aimed at r0
	zeroReg: assert property (@(posedge clk) disable iff (!rstN)
		(rdAddrA == '0) |-> (rdDataA == '0))
		else $error("r0 read back nonzero");

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
	input  logic [cpuPkg::dataWidth-1:0] srcA,
	input  logic [cpuPkg::dataWidth-1:0] srcB,
	input  logic [4:0]                   shamt,
	input  cpuPkg::aluOpT                aluOp,
	output logic [cpuPkg::dataWidth-1:0] result,
	output logic                         zero
);
	import cpuPkg::*;

	logic lessThan;

	// Signed compare for slt
	assign lessThan = $signed(srcA) < $signed(srcB);

	always_comb begin
		case (aluOp)
			aluAdd: result = srcA + srcB;
			aluSub: result = srcA - srcB;
			aluAnd: result = srcA & srcB;
			aluOr:  result = srcA | srcB;
			aluXor: result = srcA ^ srcB;
			aluSlt: result = {{(dataWidth-1){1'b0}}, lessThan};
			// Shifts act on rt, amount from the instruction
			aluSll: result = srcB << shamt;
			aluSrl: result = srcB >> shamt;
			aluSra: result = $signed(srcB) >>> shamt;
			aluLui: result = {srcB[dataWidth/2-1:0], {(dataWidth/2){1'b0}}};
			default: result = '0;
		endcase
	end

	// Used by beq/bne after a subtract
	assign zero = (result == '0);

endmodule

`default_nettype wire

/* storeAlign.sv */
`timescale 1ns/10ps
`default_nettype none

module storeAlign (
	input  logic [cpuPkg::dataWidth-1:0] storeData,
	input  logic [cpuPkg::dataWidth-1:0] addrIn,
	input  cpuPkg::memSizeT              memSize,
	output logic [cpuPkg::dataWidth-1:0] memDataW,
	output logic [cpuPkg::dataWidth-1:0] memAdr,
	output logic [1:0]                   memLane
);
	import cpuPkg::*;

	// Replicate so any lane the memory picks holds the data
	always_comb begin
		case (memSize)
			sizeByte: memDataW = {4{storeData[7:0]}};
			sizeHalf: memDataW = {2{storeData[15:0]}};
			default:  memDataW = storeData;
		endcase
	end

	// Word address plus lane select
	assign memAdr  = {addrIn[dataWidth-1:2], 2'b00};
	assign memLane = addrIn[1:0];

endmodule

`default_nettype wire

/* loadAlign.sv */
`timescale 1ns/10ps
`default_nettype none

module loadAlign (
	input  logic [cpuPkg::dataWidth-1:0] memData,
	input  logic [1:0]                   lane,
	input  cpuPkg::memSizeT              memSize,
	input  logic                         loadUnsigned,
	output logic [cpuPkg::dataWidth-1:0] loadData
);
	import cpuPkg::*;

	logic [7:0]  byteSel;
	logic [15:0] halfSel;

	// Little-endian lanes
	always_comb begin
		case (lane)
			2'd0: byteSel = memData[7:0];
			2'd1: byteSel = memData[15:8];
			2'd2: byteSel = memData[23:16];
			default: byteSel = memData[31:24];
		endcase
	end

	assign halfSel = lane[1] ? memData[31:16] : memData[15:0];

	always_comb begin
		case (memSize)
			sizeByte: loadData = {{(dataWidth-8){byteSel[7] & ~loadUnsigned}}, byteSel};
			sizeHalf: loadData = {{(dataWidth-16){halfSel[15] & ~loadUnsigned}}, halfSel};
			default:  loadData = memData;
		endcase
	end

	// lane[0] is simply dropped for halves
	always_comb begin
		if (memSize == sizeHalf) begin
			halfAligned: assert final (lane[0] == 1'b0)
				else $error("half access at odd byte lane %0d", lane);
		end
	end

endmodule

`default_nettype wire

/* controlUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
	input  logic [cpuPkg::dataWidth-1:0] instr,
	input  logic                         rstN,
	output logic                         isBranch,
	output logic                         branchOnEqual,
	output logic                         jump,
	output logic                         jumpReg,
	output logic                         destFromRt,
	output logic                         saveRa,
	output cpuPkg::wbSelT                wbSel,
	output logic                         regWe,
	output logic                         aluBFromImm,
	output cpuPkg::extModeT              extMode,
	output cpuPkg::aluOpT                aluOp,
	output cpuPkg::memSizeT              memSize,
	output logic                         loadUnsigned,
	output logic                         memWe
);
	import cpuPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic       regWeDec;
	logic       memWeDec;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////
	always_comb begin
		// Defaults form a no-op
		isBranch      = 1'b0;
		branchOnEqual = 1'b0;
		jump          = 1'b0;
		jumpReg       = 1'b0;
		destFromRt    = 1'b0;
		saveRa        = 1'b0;
		wbSel         = wbAlu;
		regWeDec      = 1'b0;
		aluBFromImm   = 1'b0;
		extMode       = extSign;
		aluOp         = aluAdd;
		memSize       = sizeWord;
		loadUnsigned  = 1'b0;
		memWeDec      = 1'b0;
		case (opcode)
			opRType: begin
				regWeDec = 1'b1;
				case (funct)
					fnAddu: aluOp = aluAdd;
					fnSubu: aluOp = aluSub;
					fnAnd:  aluOp = aluAnd;
					fnOr:   aluOp = aluOr;
					fnXor:  aluOp = aluXor;
					fnSlt:  aluOp = aluSlt;
					fnSll:  aluOp = aluSll;
					fnSrl:  aluOp = aluSrl;
					fnSra:  aluOp = aluSra;
					fnJr: begin
						jumpReg  = 1'b1;
						regWeDec = 1'b0;
					end
					default: regWeDec = 1'b0;
				endcase
			end
			opJ: jump = 1'b1;
			opJal: begin
				jump     = 1'b1;
				saveRa   = 1'b1;
				wbSel    = wbLink;
				regWeDec = 1'b1;
			end
			// Branches compare rs and rt through a subtract
			opBeq, opBne: begin
				isBranch      = 1'b1;
				branchOnEqual = (opcode == opBeq);
				extMode       = extShift2;
				aluOp         = aluSub;
			end
			opAddiu, opAndi, opOri, opLui: begin
				destFromRt  = 1'b1;
				aluBFromImm = 1'b1;
				regWeDec    = 1'b1;
				if (opcode == opAndi || opcode == opOri) begin
					extMode = extZero;
				end
				if (opcode == opAndi) begin
					aluOp = aluAnd;
				end else if (opcode == opOri) begin
					aluOp = aluOr;
				end else if (opcode == opLui) begin
					aluOp = aluLui;
				end
			end
			opLw, opLh, opLhu, opLb, opLbu: begin
				destFromRt   = 1'b1;
				aluBFromImm  = 1'b1;
				wbSel        = wbLoad;
				regWeDec     = 1'b1;
				loadUnsigned = (opcode == opLhu) || (opcode == opLbu);
				if (opcode == opLh || opcode == opLhu) begin
					memSize = sizeHalf;
				end else if (opcode == opLb || opcode == opLbu) begin
					memSize = sizeByte;
				end
			end
			opSw, opSh, opSb: begin
				aluBFromImm = 1'b1;
				memWeDec    = 1'b1;
				if (opcode == opSh) begin
					memSize = sizeHalf;
				end else if (opcode == opSb) begin
					memSize = sizeByte;
				end
			end
			default: ;
		endcase
	end

	// No writes of any kind while held in reset
	assign regWe = regWeDec & rstN;
	assign memWe = memWeDec & rstN;

endmodule

`default_nettype wire

/* datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module datapath #(
	parameter logic [cpuPkg::dataWidth-1:0] resetPc = '0
) (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic [cpuPkg::dataWidth-1:0] instr,
	input  logic                         isBranch,
	input  logic                         branchOnEqual,
	input  logic                         jump,
	input  logic                         jumpReg,
	input  logic                         destFromRt,
	input  logic                         saveRa,
	input  cpuPkg::wbSelT                wbSel,
	input  logic                         regWe,
	input  logic                         aluBFromImm,
	input  cpuPkg::extModeT              extMode,
	input  cpuPkg::aluOpT                aluOp,
	input  cpuPkg::memSizeT              memSize,
	input  logic                         loadUnsigned,
	input  logic [cpuPkg::dataWidth-1:0] memDataR,
	output logic [cpuPkg::dataWidth-1:0] pc,
	output logic [cpuPkg::dataWidth-1:0] memAdr,
	output logic [cpuPkg::dataWidth-1:0] memDataW,
	output logic [1:0]                   memLane
);
	import cpuPkg::*;

	// Instruction fields
	logic [regAddrWidth-1:0] rs, rt, rd, destAddr;
	logic [15:0]             imm;
	logic [dataWidth-1:0]    pcPlus4, extImm, rdDataA, rdDataB, wbData;
	logic [dataWidth-1:0]    aluSrcB, aluResult, loadData;
	logic                    aluZero, branchTaken;

	assign rs  = instr[25:21];
	assign rt  = instr[20:16];
	assign rd  = instr[15:11];
	assign imm = instr[15:0];

	////////////////////////////////////////////////////////////
	// PC and branch test
	////////////////////////////////////////////////////////////
	// bne takes the branch on a nonzero difference
	assign branchTaken = isBranch && (aluZero == branchOnEqual);

	nextPc #(.resetPc(resetPc)) nextPc_inst (
		.clk(clk), .rstN(rstN), .branchImm(extImm), .jumpImm(instr[25:0]),
		.regTarget(rdDataA), .branchTaken(branchTaken), .jump(jump),
		.jumpReg(jumpReg), .pc(pc), .pcPlus4(pcPlus4)
	);

	////////////////////////////////////////////////////////////
	// Register file and write-back
	////////////////////////////////////////////////////////////
	assign destAddr = saveRa ? regAddrWidth'(31) : (destFromRt ? rt : rd);

	always_comb begin
		case (wbSel)
			wbLoad:  wbData = loadData;
			wbLink:  wbData = pcPlus4;
			default: wbData = aluResult;
		endcase
	end

	regFile regFile_inst (
		.clk(clk), .rstN(rstN), .rdAddrA(rs), .rdAddrB(rt), .wrAddr(destAddr),
		.wrData(wbData), .we(regWe), .rdDataA(rdDataA), .rdDataB(rdDataB)
	);

	////////////////////////////////////////////////////////////
	// Extender and ALU
	////////////////////////////////////////////////////////////
	always_comb begin
		case (extMode)
			extZero:   extImm = {{(dataWidth-16){1'b0}}, imm};
			extShift2: extImm = {{(dataWidth-18){imm[15]}}, imm, 2'b00};
			default:   extImm = {{(dataWidth-16){imm[15]}}, imm};
		endcase
	end

	assign aluSrcB = aluBFromImm ? extImm : rdDataB;

	alu alu_inst (
		.srcA(rdDataA), .srcB(aluSrcB), .shamt(instr[10:6]), .aluOp(aluOp),
		.result(aluResult), .zero(aluZero)
	);

	// Store side, then load side on the same lane bits
	storeAlign storeAlign_inst (
		.storeData(rdDataB), .addrIn(aluResult), .memSize(memSize),
		.memDataW(memDataW), .memAdr(memAdr), .memLane(memLane)
	);

	loadAlign loadAlign_inst (
		.memData(memDataR), .lane(memLane), .memSize(memSize),
		.loadUnsigned(loadUnsigned), .loadData(loadData)
	);

endmodule

`default_nettype wire

/* dataMem.sv */
`timescale 1ns/10ps
`default_nettype none

module dataMem #(
	parameter int memWords = 256
) (
	input  logic                         clk,
	input  logic                         we,
	input  logic [cpuPkg::dataWidth-1:0] adr,
	input  logic [cpuPkg::dataWidth-1:0] dataW,
	input  logic [1:0]                   lane,
	input  cpuPkg::memSizeT              memSize,
	output logic [cpuPkg::dataWidth-1:0] dataR
);
	import cpuPkg::*;

	localparam int idxWidth = $clog2(memWords);

	logic [dataWidth-1:0] mem [memWords];
	logic [idxWidth-1:0]  idx;
	logic [3:0]           laneEn;

	assign idx = adr[idxWidth+1:2];

	// Byte enables
	always_comb begin
		case (memSize)
			sizeByte: laneEn = 4'b0001 << lane;
			sizeHalf: laneEn = lane[1] ? 4'b1100 : 4'b0011;
			default:  laneEn = 4'b1111;
		endcase
	end

	// data is already replicated, lane b writes its own byte
	always_ff @(posedge clk) begin
		if (we) begin
			for (int b = 0; b < 4; b++) begin
				if (laneEn[b]) begin
					mem[idx][8*b +: 8] <= dataW[8*b +: 8];
				end
			end
		end
	end

	assign dataR = mem[idx];

	adrInRange: assert property (@(posedge clk) we |-> (adr < memWords * 4))
		else $error("store address %h beyond memory", adr);

endmodule

`default_nettype wire

/* cpuCore.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuCore #(
	parameter logic [cpuPkg::dataWidth-1:0] resetPc  = '0,
	parameter int                           memWords = 256
) (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic [cpuPkg::dataWidth-1:0] instr,
	output logic [cpuPkg::dataWidth-1:0] pc,
	output logic                         memWe,
	output logic [cpuPkg::dataWidth-1:0] memAdr,
	output logic [cpuPkg::dataWidth-1:0] memDataW,
	output cpuPkg::memSizeT              memSize,
	output logic [1:0]                   memLane
);
	import cpuPkg::*;

	// Decoder to datapath
	logic    isBranch, branchOnEqual, jump, jumpReg, destFromRt, saveRa;
	logic    regWe, aluBFromImm, loadUnsigned;
	wbSelT   wbSel;
	extModeT extMode;
	aluOpT   aluOp;
	logic [dataWidth-1:0] memDataR;

	controlUnit controlUnit_inst (
		.instr(instr), .rstN(rstN), .isBranch(isBranch), .branchOnEqual(branchOnEqual),
		.jump(jump), .jumpReg(jumpReg), .destFromRt(destFromRt), .saveRa(saveRa),
		.wbSel(wbSel), .regWe(regWe), .aluBFromImm(aluBFromImm), .extMode(extMode),
		.aluOp(aluOp), .memSize(memSize), .loadUnsigned(loadUnsigned), .memWe(memWe)
	);

	datapath #(.resetPc(resetPc)) datapath_inst (
		.clk(clk), .rstN(rstN), .instr(instr), .isBranch(isBranch),
		.branchOnEqual(branchOnEqual), .jump(jump), .jumpReg(jumpReg),
		.destFromRt(destFromRt), .saveRa(saveRa), .wbSel(wbSel), .regWe(regWe),
		.aluBFromImm(aluBFromImm), .extMode(extMode), .aluOp(aluOp), .memSize(memSize),
		.loadUnsigned(loadUnsigned), .memDataR(memDataR), .pc(pc), .memAdr(memAdr),
		.memDataW(memDataW), .memLane(memLane)
	);

	dataMem #(.memWords(memWords)) dataMem_inst (
		.clk(clk), .we(memWe), .adr(memAdr), .dataW(memDataW), .lane(memLane),
		.memSize(memSize), .dataR(memDataR)
	);

endmodule

`default_nettype wire

/* tbCpuCore.sv */
`timescale 1ns/10ps
`default_nettype none

module tbCpuCore;
	import cpuPkg::*;

	localparam logic [31:0] resetPc = 32'h0000_0040;
	localparam int memWords = 256;

	logic                 clk;
	logic                 rstN;
	logic [dataWidth-1:0] instr;
	logic [dataWidth-1:0] pc;
	logic                 memWe;
	logic [dataWidth-1:0] memAdr;
	logic [dataWidth-1:0] memDataW;
	memSizeT              memSize;
	logic [1:0]           memLane;

	// Program table, one entry per instruction
	logic [31:0] progInstr[$];
	logic [31:0] progPc[$];
	logic        progWe[$];
	logic [31:0] progAdr[$];
	logic [31:0] progData[$];
	logic [1:0]  progSize[$];
	logic [1:0]  progLane[$];

	int cycleCount = 0;
	int cycleLimit = 1000;

	cpuCore #(.resetPc(resetPc), .memWords(memWords)) cpuCore_inst (
		.clk(clk), .rstN(rstN), .instr(instr), .pc(pc), .memWe(memWe), .memAdr(memAdr),
		.memDataW(memDataW), .memSize(memSize), .memLane(memLane)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	//////////////////////////////////////////////////////////////
	// Instruction encoders and table builders
	//////////////////////////////////////////////////////////////
	function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {opRType, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encJ(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	task automatic addRow(input logic [31:0] ins, input logic [31:0] expPc);
		progInstr.push_back(ins);
		progPc.push_back(expPc);
		progWe.push_back(1'b0);
		progAdr.push_back('0);
		progData.push_back('0);
		progSize.push_back('0);
		progLane.push_back('0);
	endtask

	task automatic addStore(input logic [31:0] ins, input logic [31:0] expPc,
			input logic [31:0] adr, input logic [31:0] data, input logic [1:0] size,
			input logic [1:0] lane);
		progInstr.push_back(ins);
		progPc.push_back(expPc);
		progWe.push_back(1'b1);
		progAdr.push_back(adr);
		progData.push_back(data);
		progSize.push_back(size);
		progLane.push_back(lane);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			$display("Verification failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic buildProgram();
		// Arithmetic and logic, base pointer r1 = 0x100
		addRow(encI(opLui, 0, 2, 16'h1234), 32'h40);
		addRow(encI(opOri, 2, 2, 16'h5678), 32'h44);
		addRow(encI(opAddiu, 0, 1, 16'h0100), 32'h48);
		addRow(encI(opAddiu, 0, 3, 16'hfffd), 32'h4c);
		addRow(encR(2, 3, 4, 0, fnAddu), 32'h50);
		addStore(encI(opSw, 1, 4, 16'd0), 32'h54, 32'h100, 32'h12345675, sizeWord, 2'd0);
		addRow(encR(3, 2, 5, 0, fnSubu), 32'h58);
		addStore(encI(opSw, 1, 5, 16'd4), 32'h5c, 32'h104, 32'hedcba985, sizeWord, 2'd0);
		addRow(encI(opAndi, 3, 6, 16'hff0f), 32'h60);
		addRow(encR(2, 6, 7, 0, fnOr), 32'h64);
		addRow(encR(7, 5, 8, 0, fnAnd), 32'h68);
		addRow(encR(2, 4, 9, 0, fnXor), 32'h6c);
		addStore(encI(opSw, 1, 7, 16'd8), 32'h70, 32'h108, 32'h1234ff7d, sizeWord, 2'd0);
		addStore(encI(opSw, 1, 8, 16'd12), 32'h74, 32'h10c, 32'h0000a905, sizeWord, 2'd0);
		addStore(encI(opSw, 1, 9, 16'd16), 32'h78, 32'h110, 32'h0000000d, sizeWord, 2'd0);
		// slt is signed, so -3 is less
		addRow(encR(3, 2, 10, 0, fnSlt), 32'h7c);
		addRow(encR(2, 3, 11, 0, fnSlt), 32'h80);
		addStore(encI(opSw, 1, 10, 16'd20), 32'h84, 32'h114, 32'h00000001, sizeWord, 2'd0);
		addStore(encI(opSw, 1, 11, 16'd24), 32'h88, 32'h118, 32'h00000000, sizeWord, 2'd0);
		addRow(encR(0, 2, 12, 4, fnSll), 32'h8c);
		addRow(encR(0, 5, 13, 8, fnSrl), 32'h90);
		addRow(encR(0, 5, 14, 8, fnSra), 32'h94);
		addStore(encI(opSw, 1, 12, 16'd28), 32'h98, 32'h11c, 32'h23456780, sizeWord, 2'd0);
		addStore(encI(opSw, 1, 13, 16'd32), 32'h9c, 32'h120, 32'h00edcba9, sizeWord, 2'd0);
		addStore(encI(opSw, 1, 14, 16'd36), 32'ha0, 32'h124, 32'hffedcba9, sizeWord, 2'd0);
		// Sub-word stores replicate their data
		addStore(encI(opSb, 1, 5, 16'd41), 32'ha4, 32'h128, 32'h85858585, sizeByte, 2'd1);
		addStore(encI(opSh, 1, 2, 16'd46), 32'ha8, 32'h12c, 32'h56785678, sizeHalf, 2'd2);
		// Loads, each result stored back as a word
		addRow(encI(opLb, 1, 15, 16'd41), 32'hac);
		addRow(encI(opLbu, 1, 16, 16'd41), 32'hb0);
		addRow(encI(opLh, 1, 17, 16'd6), 32'hb4);
		addRow(encI(opLhu, 1, 18, 16'd6), 32'hb8);
		addRow(encI(opLw, 1, 19, 16'd0), 32'hbc);
		addStore(encI(opSw, 1, 15, 16'd48), 32'hc0, 32'h130, 32'hffffff85, sizeWord, 2'd0);
		addStore(encI(opSw, 1, 16, 16'd52), 32'hc4, 32'h134, 32'h00000085, sizeWord, 2'd0);
		addStore(encI(opSw, 1, 17, 16'd56), 32'hc8, 32'h138, 32'hffffedcb, sizeWord, 2'd0);
		addStore(encI(opSw, 1, 18, 16'd60), 32'hcc, 32'h13c, 32'h0000edcb, sizeWord, 2'd0);
		addStore(encI(opSw, 1, 19, 16'd64), 32'hd0, 32'h140, 32'h12345675, sizeWord, 2'd0);
		// r0 stays zero after a write
		addRow(encI(opAddiu, 0, 0, 16'h0055), 32'hd4);
		addStore(encI(opSw, 1, 0, 16'd68), 32'hd8, 32'h144, 32'h00000000, sizeWord, 2'd0);
		// Branches: not taken, taken, not taken, taken
		addRow(encI(opBeq, 2, 4, 16'd8), 32'hdc);
		addRow(encI(opBeq, 4, 19, 16'd2), 32'he0);
		addRow(encI(opBne, 4, 19, 16'd5), 32'hec);
		addRow(encI(opBne, 2, 4, 16'd1), 32'hf0);
		// jal links 0xfc into r31
		addRow(encJ(opJal, 26'h80), 32'hf8);
		addStore(encI(opSw, 1, 31, 16'd72), 32'h200, 32'h148, 32'h000000fc, sizeWord, 2'd0);
		addRow(encI(opAddiu, 0, 20, 16'h0300), 32'h204);
		addRow(encR(20, 0, 0, 0, fnJr), 32'h208);
		addRow(encJ(opJ, 26'h60), 32'h300);
		addStore(encI(opSw, 1, 20, 16'd76), 32'h180, 32'h14c, 32'h00000300, sizeWord, 2'd0);
	endtask

	//////////////////////////////////////////////////////////////
	// Timeout
	//////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Program did not finish within %0d cycles", cycleLimit);
			$display("Verification failed");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////
	initial begin
		rstN = 1'b0;
		// A store held on instr shows memWe is gated in reset
		instr = encI(opSw, 0, 0, 16'd0);
		buildProgram();
		cycleLimit = progInstr.size() + 4 + 10;

		repeat (3) begin
			@(posedge clk);
			@(negedge clk);
			checkValue("memWe", 32'd0, 32'(memWe));
			checkValue("pc", resetPc, pc);
		end

		// Reset is released on the edge that applies row 0
		for (int i = 0; i < progInstr.size(); i++) begin
			@(posedge clk);
			rstN <= 1'b1;
			instr <= progInstr[i];
			@(negedge clk);
			checkValue("pc", progPc[i], pc);
			checkValue("memWe", 32'(progWe[i]), 32'(memWe));
			if (progWe[i]) begin
				checkValue("memAdr", progAdr[i], memAdr);
				checkValue("memDataW", progData[i], memDataW);
				checkValue("memSize", 32'(progSize[i]), 32'(memSize));
				checkValue("memLane", 32'(progLane[i]), 32'(memLane));
			end
		end

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
cpuPkg.sv
nextPc.sv
regFile.sv
alu.sv
storeAlign.sv
loadAlign.sv
controlUnit.sv
datapath.sv
dataMem.sv
cpuCore.sv
tbCpuCore.sv
